/* idli_ex_pkg.sv */
// Shared widths, field encodings and the instruction word layout for the
// nibble-serial execution unit.
package idli_ex_pkg;

  // Word, nibble and register file geometry.
  localparam int DATA_W  = 16;
  localparam int SLICE_W = 4;
  localparam int SLICES  = DATA_W / SLICE_W;
  localparam int REGS    = 16;
  localparam int PINS    = 4;
  localparam int COND_W  = 8;

  // One slot counter value per nibble of the word.
  typedef logic [$clog2(SLICES)-1:0] ctr_t;
  typedef logic [SLICE_W-1:0]        slice_t;
  typedef logic [DATA_W-1:0]         data_t;
  typedef logic [$clog2(REGS)-1:0]   reg_t;

  // Register 0 is hardwired to zero.
  localparam reg_t REG_ZR = '0;

  // Opcodes. Any value not listed here executes as a no-operation.
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_CMP  = 4'd5,
    OP_COND = 4'd6,
    OP_PIN  = 4'd7
  } op_t;

  // Compare kinds, carried in the dst field of a CMP.
  typedef enum logic [3:0] {
    CMP_EQ  = 4'd0,
    CMP_NE  = 4'd1,
    CMP_LT  = 4'd2,
    CMP_LTU = 4'd3,
    CMP_GE  = 4'd4,
    CMP_GEU = 4'd5
  } cmp_op_t;

  // Pin operations, carried in imm8[3:2] of a PIN.
  typedef enum logic [1:0] {
    PIN_IN   = 2'd0,
    PIN_OUT  = 2'd1,
    PIN_OUTN = 2'd2,
    PIN_PRED = 2'd3
  } pin_op_t;

  // Three register operands.
  typedef struct packed {
    op_t  op;
    reg_t dst;
    reg_t lhs;
    reg_t rhs;
  } instr_alu_t;

  // One register and an 8-bit immediate.
  typedef struct packed {
    op_t        op;
    reg_t       rg;
    logic [7:0] imm8;
  } instr_imm_t;

  // The same instruction word read through either layout.
  typedef union packed {
    instr_alu_t alu;
    instr_imm_t imm;
  } instr_u;

endpackage

/* idli_ex_fetch.sv */
`timescale 1ns/10ps

// Slot counter and instruction capture. A new word is only taken on the
// last cycle of a slot so that execution always starts on nibble 0.
module idli_ex_fetch import idli_ex_pkg::*; (
  input  var logic   i_ex_gck,
  input  var logic   i_ex_rst_n,

  // Instruction strobe from outside.
  input  var data_t  i_ex_enc,
  input  var logic   i_ex_enc_vld,

  // Slot position and the captured instruction.
  output var ctr_t   o_ex_ctr,
  output var logic   o_ex_enc_acp,
  output var instr_u o_ex_instr,
  output var logic   o_ex_instr_vld
);

  ctr_t   ctr_q;
  instr_u instr_q;
  logic   instr_vld_q;

  // The counter free-runs and wraps every four cycles.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      ctr_q <= '0;
    end else begin
      ctr_q <= ctr_q + ctr_t'(1);
    end
  end

  // Words are accepted during the final slice of the current slot.
  always_comb o_ex_enc_acp = &ctr_q;

  // The valid level is rewritten every slot, so a word that was not
  // offered at the boundary leaves an empty slot behind it.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      instr_vld_q <= '0;
    end else if (o_ex_enc_acp) begin
      instr_vld_q <= i_ex_enc_vld;
    end
  end

  // The word itself only matters while the valid level is high.
  always_ff @(posedge i_ex_gck) begin
    if (o_ex_enc_acp) begin
      instr_q <= instr_u'(i_ex_enc);
    end
  end

  always_comb o_ex_ctr       = ctr_q;
  always_comb o_ex_instr     = instr_q;
  always_comb o_ex_instr_vld = instr_vld_q;

endmodule

/* idli_ex_decode.sv */
`timescale 1ns/10ps

// Instruction decoder. Register operations are read through the ALU view
// of the word, while COND and PIN are read through the immediate view.
module idli_ex_decode import idli_ex_pkg::*; (
  input  var instr_u            i_ex_instr,
  input  var logic              i_ex_instr_vld,

  // Operation and register indices.
  output var op_t               o_ex_op,
  output var reg_t              o_ex_lhs_reg,
  output var reg_t              o_ex_rhs_reg,
  output var reg_t              o_ex_dst_reg,
  output var logic              o_ex_dst_wr,

  // Compare, conditional mask and pin controls.
  output var cmp_op_t           o_ex_cmp_op,
  output var logic              o_ex_cond_wr,
  output var logic [COND_W-1:0] o_ex_cond_data,
  output var pin_op_t           o_ex_pin_op,
  output var logic [1:0]        o_ex_pin_idx,
  output var logic              o_ex_pin_vld
);

  always_comb begin
    // The opcode sits in the same place in both views.
    o_ex_op      = i_ex_instr.alu.op;
    o_ex_lhs_reg = i_ex_instr.alu.lhs;
    o_ex_rhs_reg = i_ex_instr.alu.rhs;
    o_ex_dst_reg = i_ex_instr.alu.dst;
    o_ex_dst_wr  = '0;

    // A CMP reuses its dst field to say which comparison to make.
    o_ex_cmp_op    = cmp_op_t'(i_ex_instr.alu.dst);
    o_ex_cond_wr   = '0;
    o_ex_cond_data = i_ex_instr.imm.imm8;

    // Pin index and pin operation live in the low bits of imm8.
    o_ex_pin_op  = pin_op_t'(i_ex_instr.imm.imm8[3:2]);
    o_ex_pin_idx = i_ex_instr.imm.imm8[1:0];
    o_ex_pin_vld = '0;

    case (i_ex_instr.alu.op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
        o_ex_dst_wr = i_ex_instr_vld;
      end
      OP_COND: begin
        o_ex_cond_wr = i_ex_instr_vld;
      end
      OP_PIN: begin
        o_ex_pin_vld = i_ex_instr_vld;
        // Output operations read reg through the ALU so that bit 0 of it
        // can be picked up on the first slice.
        o_ex_lhs_reg = i_ex_instr.imm.rg;
        o_ex_rhs_reg = REG_ZR;
        // An input operation writes the sampled pin back to reg instead.
        o_ex_dst_reg = i_ex_instr.imm.rg;
        o_ex_dst_wr  = i_ex_instr_vld && o_ex_pin_op == PIN_IN;
      end
      default: begin
        // CMP only writes the predicate, and no-operations write nothing.
      end
    endcase
  end

endmodule

/* idli_ex_rf.sv */
`timescale 1ns/10ps

// Register file stored as nibbles. Each port reads and writes the nibble
// chosen by the slot counter, so a whole word takes one slot.
module idli_ex_rf import idli_ex_pkg::*; (
  input  var logic   i_ex_gck,
  input  var ctr_t   i_ex_ctr,

  // Read ports.
  input  var reg_t   i_ex_lhs_reg,
  input  var reg_t   i_ex_rhs_reg,
  output var slice_t o_ex_lhs_data,
  output var slice_t o_ex_rhs_data,

  // Write port.
  input  var reg_t   i_ex_dst_reg,
  input  var logic   i_ex_dst_wr,
  input  var slice_t i_ex_dst_data
);

  slice_t regs_q [REGS][SLICES];

  // Reads are combinational. Register 0 is never stored, so its
  // value is forced here.
  always_comb begin
    o_ex_lhs_data = '0;
    o_ex_rhs_data = '0;

    if (i_ex_lhs_reg != REG_ZR) begin
      o_ex_lhs_data = regs_q[i_ex_lhs_reg][i_ex_ctr];
    end

    if (i_ex_rhs_reg != REG_ZR) begin
      o_ex_rhs_data = regs_q[i_ex_rhs_reg][i_ex_ctr];
    end
  end

  // A nibble is written at the edge that ends its slice.
  always_ff @(posedge i_ex_gck) begin
    if (i_ex_dst_wr && i_ex_dst_reg != REG_ZR) begin
      regs_q[i_ex_dst_reg][i_ex_ctr] <= i_ex_dst_data;
    end
  end

endmodule

/* idli_ex_alu.sv */
`timescale 1ns/10ps

// Nibble-serial ALU. The carry from each slice feeds the next one, and the
// flags describe the whole word once the last slice is reached.
module idli_ex_alu import idli_ex_pkg::*; (
  input  var logic   i_ex_gck,
  input  var ctr_t   i_ex_ctr,
  input  var op_t    i_ex_op,

  // Operand and result nibbles.
  input  var slice_t i_ex_lhs,
  input  var slice_t i_ex_rhs,
  output var slice_t o_ex_out,

  // Flags, valid during slice 3.
  output var logic   o_ex_flag_z,
  output var logic   o_ex_flag_n,
  output var logic   o_ex_flag_c,
  output var logic   o_ex_flag_v
);

  logic               sub;
  logic               cin;
  slice_t             rhs_eff;
  logic [SLICE_W:0]   sum;
  logic               carry_q;
  logic               zero_q;

  // Subtraction is lhs plus the inverse of rhs plus one.
  always_comb sub     = i_ex_op == OP_SUB || i_ex_op == OP_CMP;
  always_comb rhs_eff = sub ? ~i_ex_rhs : i_ex_rhs;
  always_comb cin     = i_ex_ctr == '0 ? sub : carry_q;
  always_comb sum     = {1'b0, i_ex_lhs} + {1'b0, rhs_eff} + (SLICE_W+1)'(cin);

  always_comb begin
    case (i_ex_op)
      OP_ADD, OP_SUB, OP_CMP: o_ex_out = sum[SLICE_W-1:0];
      OP_AND:                 o_ex_out = i_ex_lhs & i_ex_rhs;
      OP_OR:                  o_ex_out = i_ex_lhs | i_ex_rhs;
      OP_XOR:                 o_ex_out = i_ex_lhs ^ i_ex_rhs;
      // PIN uses the ALU only to carry reg through to io.
      OP_PIN:                 o_ex_out = i_ex_lhs;
      default:                o_ex_out = '0;
    endcase
  end

  // Zero is sticky across the slot and restarts at slice 0.
  always_comb o_ex_flag_z = (i_ex_ctr == '0 || zero_q) && o_ex_out == '0;

  // The rest only mean something on the top nibble.
  always_comb o_ex_flag_n = o_ex_out[SLICE_W-1];
  always_comb o_ex_flag_c = sum[SLICE_W];
  always_comb o_ex_flag_v = i_ex_lhs[SLICE_W-1] == rhs_eff[SLICE_W-1]
                         && o_ex_out[SLICE_W-1] != i_ex_lhs[SLICE_W-1];

  always_ff @(posedge i_ex_gck) begin
    carry_q <= sum[SLICE_W];
    zero_q  <= o_ex_flag_z;
  end

endmodule

/* idli_ex_pred.sv */
`timescale 1ns/10ps

// Predicate register and conditional execution mask.
module idli_ex_pred import idli_ex_pkg::*; (
  input  var logic              i_ex_gck,
  input  var logic              i_ex_rst_n,
  input  var ctr_t              i_ex_ctr,

  // Decoded instruction controls.
  input  var logic              i_ex_instr_vld,
  input  var op_t               i_ex_op,
  input  var cmp_op_t           i_ex_cmp_op,
  input  var logic              i_ex_cond_wr,
  input  var logic [COND_W-1:0] i_ex_cond_data,

  // Flags from the ALU at slice 3.
  input  var logic              i_ex_flag_z,
  input  var logic              i_ex_flag_n,
  input  var logic              i_ex_flag_c,
  input  var logic              i_ex_flag_v,

  output var logic              o_ex_skip,
  output var logic              o_ex_pred
);

  logic              pred_q;
  logic [COND_W-1:0] mask_q;
  logic              cmp_res;
  logic              slot_end;

  always_comb slot_end = &i_ex_ctr;

  // The mask is live while anything above bit 0 is set. Bit 0 then says
  // which predicate value lets the instruction run.
  always_comb o_ex_skip = |mask_q[COND_W-1:1] && (mask_q[0] != pred_q);

  // Outcome of lhs minus rhs for each kind of compare.
  always_comb begin
    case (i_ex_cmp_op)
      CMP_EQ:  cmp_res = i_ex_flag_z;
      CMP_NE:  cmp_res = !i_ex_flag_z;
      CMP_LT:  cmp_res = i_ex_flag_n != i_ex_flag_v;
      CMP_LTU: cmp_res = !i_ex_flag_c;
      CMP_GE:  cmp_res = i_ex_flag_n == i_ex_flag_v;
      CMP_GEU: cmp_res = i_ex_flag_c;
      default: cmp_res = pred_q;
    endcase
  end

  // Both registers move on the edge that ends the slot. Every taken
  // instruction shifts the mask, unless it is a COND that runs.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      pred_q <= '0;
      mask_q <= '0;
    end else if (slot_end && i_ex_instr_vld) begin
      if (i_ex_op == OP_CMP && !o_ex_skip) begin
        pred_q <= cmp_res;
      end

      if (i_ex_cond_wr && !o_ex_skip) begin
        mask_q <= i_ex_cond_data;
      end else begin
        mask_q <= mask_q >> 1;
      end
    end
  end

  always_comb o_ex_pred = pred_q;

endmodule

/* idli_ex_io.sv */
`timescale 1ns/10ps

// Pin handling and write-back. This block also picks the register write
// nibble and applies the skip to the register write enable.
module idli_ex_io import idli_ex_pkg::*; (
  input  var logic            i_ex_gck,
  input  var logic            i_ex_rst_n,
  input  var ctr_t            i_ex_ctr,

  // External pins.
  input  var logic [PINS-1:0] i_ex_io_pins,
  output var logic [PINS-1:0] o_ex_io_pins,

  // Pin controls and execution state.
  input  var pin_op_t         i_ex_pin_op,
  input  var logic [1:0]      i_ex_pin_idx,
  input  var logic            i_ex_pin_vld,
  input  var logic            i_ex_skip,
  input  var logic            i_ex_pred,

  // Result path to the register file.
  input  var slice_t          i_ex_res,
  input  var reg_t            i_ex_dst_reg,
  input  var logic            i_ex_dst_wr,
  output var slice_t          o_ex_pin_data,
  output var logic            o_ex_dst_wr,

  // Write-back trace.
  output var logic            o_ex_wb_vld,
  output var reg_t            o_ex_wb_reg,
  output var data_t           o_ex_wb_data
);

  logic [PINS-1:0] in_pins_q;
  logic [PINS-1:0] out_pins_q;
  logic            pin_in;
  logic            slot_end;
  logic            wb_vld_q;
  reg_t            wb_reg_q;
  data_t           wb_data_q;

  always_comb slot_end = &i_ex_ctr;
  always_comb pin_in   = i_ex_pin_vld && i_ex_pin_op == PIN_IN;

  // Inputs are registered once before use.
  always_ff @(posedge i_ex_gck) begin
    in_pins_q <= i_ex_io_pins;
  end

  // The sampled pin fills bit 0 of nibble 0 and the rest of the word is
  // zero. Everything else writes the ALU result.
  always_comb begin
    o_ex_pin_data = i_ex_res;

    if (pin_in) begin
      o_ex_pin_data = i_ex_ctr == '0 ? slice_t'(in_pins_q[i_ex_pin_idx]) : '0;
    end
  end

  always_comb o_ex_dst_wr = i_ex_dst_wr && !i_ex_skip;

  // Gather each nibble as it is produced. For output pin operations this
  // holds reg, whose bit 0 is ready well before the slot ends.
  always_ff @(posedge i_ex_gck) begin
    wb_data_q[i_ex_ctr*SLICE_W +: SLICE_W] <= o_ex_pin_data;

    if (slot_end) begin
      wb_reg_q <= i_ex_dst_reg;
    end
  end

  // One pulse per completed register write, seen in the next cycle.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      wb_vld_q <= '0;
    end else begin
      wb_vld_q <= slot_end && o_ex_dst_wr;
    end
  end

  // Only the selected output pin changes, at the end of the slot.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      out_pins_q <= '0;
    end else if (slot_end && i_ex_pin_vld && !i_ex_skip) begin
      case (i_ex_pin_op)
        PIN_OUT:  out_pins_q[i_ex_pin_idx] <= wb_data_q[0];
        PIN_OUTN: out_pins_q[i_ex_pin_idx] <= ~wb_data_q[0];
        PIN_PRED: out_pins_q[i_ex_pin_idx] <= i_ex_pred;
        default:  out_pins_q <= out_pins_q;
      endcase
    end
  end

  always_comb o_ex_io_pins = out_pins_q;
  always_comb o_ex_wb_vld  = wb_vld_q;
  always_comb o_ex_wb_reg  = wb_reg_q;
  always_comb o_ex_wb_data = wb_data_q;

endmodule

/* idli_ex_top.sv */
`timescale 1ns/10ps

// Execution unit top level. Fetch feeds decode, the register file and ALU
// work one nibble per cycle, and io reports results and drives pins.
module idli_ex_top import idli_ex_pkg::*; (
  input  var logic            i_ex_gck,
  input  var logic            i_ex_rst_n,

  input  var data_t           i_ex_enc,
  input  var logic            i_ex_enc_vld,
  output var logic            o_ex_enc_acp,

  input  var logic [PINS-1:0] i_ex_io_pins,
  output var logic [PINS-1:0] o_ex_io_pins,
  output var logic            o_ex_pred,

  output var logic            o_ex_wb_vld,
  output var reg_t            o_ex_wb_reg,
  output var data_t           o_ex_wb_data
);

  ctr_t              ctr;
  instr_u            instr;
  logic              instr_vld;
  op_t               op;
  reg_t              lhs_reg;
  reg_t              rhs_reg;
  reg_t              dst_reg;
  logic              dst_wr;
  logic              rf_wr;
  cmp_op_t           cmp_op;
  logic              cond_wr;
  logic [COND_W-1:0] cond_data;
  pin_op_t           pin_op;
  logic [1:0]        pin_idx;
  logic              pin_vld;
  slice_t            lhs_data;
  slice_t            rhs_data;
  slice_t            alu_out;
  slice_t            wr_data;
  logic              flag_z;
  logic              flag_n;
  logic              flag_c;
  logic              flag_v;
  logic              skip;

  idli_ex_fetch fetch_u (
    .i_ex_gck       (i_ex_gck),
    .i_ex_rst_n     (i_ex_rst_n),
    .i_ex_enc       (i_ex_enc),
    .i_ex_enc_vld   (i_ex_enc_vld),
    .o_ex_ctr       (ctr),
    .o_ex_enc_acp   (o_ex_enc_acp),
    .o_ex_instr     (instr),
    .o_ex_instr_vld (instr_vld)
  );

  idli_ex_decode decode_u (
    .i_ex_instr     (instr),
    .i_ex_instr_vld (instr_vld),
    .o_ex_op        (op),
    .o_ex_lhs_reg   (lhs_reg),
    .o_ex_rhs_reg   (rhs_reg),
    .o_ex_dst_reg   (dst_reg),
    .o_ex_dst_wr    (dst_wr),
    .o_ex_cmp_op    (cmp_op),
    .o_ex_cond_wr   (cond_wr),
    .o_ex_cond_data (cond_data),
    .o_ex_pin_op    (pin_op),
    .o_ex_pin_idx   (pin_idx),
    .o_ex_pin_vld   (pin_vld)
  );

  // Writes arrive already gated by the skip decision from io.
  idli_ex_rf rf_u (
    .i_ex_gck       (i_ex_gck),
    .i_ex_ctr       (ctr),
    .i_ex_lhs_reg   (lhs_reg),
    .i_ex_rhs_reg   (rhs_reg),
    .o_ex_lhs_data  (lhs_data),
    .o_ex_rhs_data  (rhs_data),
    .i_ex_dst_reg   (dst_reg),
    .i_ex_dst_wr    (rf_wr),
    .i_ex_dst_data  (wr_data)
  );

  idli_ex_alu alu_u (
    .i_ex_gck       (i_ex_gck),
    .i_ex_ctr       (ctr),
    .i_ex_op        (op),
    .i_ex_lhs       (lhs_data),
    .i_ex_rhs       (rhs_data),
    .o_ex_out       (alu_out),
    .o_ex_flag_z    (flag_z),
    .o_ex_flag_n    (flag_n),
    .o_ex_flag_c    (flag_c),
    .o_ex_flag_v    (flag_v)
  );

  idli_ex_pred pred_u (
    .i_ex_gck       (i_ex_gck),
    .i_ex_rst_n     (i_ex_rst_n),
    .i_ex_ctr       (ctr),
    .i_ex_instr_vld (instr_vld),
    .i_ex_op        (op),
    .i_ex_cmp_op    (cmp_op),
    .i_ex_cond_wr   (cond_wr),
    .i_ex_cond_data (cond_data),
    .i_ex_flag_z    (flag_z),
    .i_ex_flag_n    (flag_n),
    .i_ex_flag_c    (flag_c),
    .i_ex_flag_v    (flag_v),
    .o_ex_skip      (skip),
    .o_ex_pred      (o_ex_pred)
  );

  idli_ex_io io_u (
    .i_ex_gck       (i_ex_gck),
    .i_ex_rst_n     (i_ex_rst_n),
    .i_ex_ctr       (ctr),
    .i_ex_io_pins   (i_ex_io_pins),
    .o_ex_io_pins   (o_ex_io_pins),
    .i_ex_pin_op    (pin_op),
    .i_ex_pin_idx   (pin_idx),
    .i_ex_pin_vld   (pin_vld),
    .i_ex_skip      (skip),
    .i_ex_pred      (o_ex_pred),
    .i_ex_res       (alu_out),
    .i_ex_dst_reg   (dst_reg),
    .i_ex_dst_wr    (dst_wr),
    .o_ex_pin_data  (wr_data),
    .o_ex_dst_wr    (rf_wr),
    .o_ex_wb_vld    (o_ex_wb_vld),
    .o_ex_wb_reg    (o_ex_wb_reg),
    .o_ex_wb_data   (o_ex_wb_data)
  );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/10ps

// Free-running 4 ns clock and a power-on reset held for four cycles.
module tb_clock_gen (
  output logic o_gck,
  output logic o_rst_n
);

  localparam real HALF_NS    = 2.0;
  localparam int  RST_CYCLES = 4;

  initial begin
    o_gck = 1'b0;
    forever #HALF_NS o_gck = ~o_gck;
  end

  // Release away from the clock edge.
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_gck);
    #0.5;
    o_rst_n = 1'b1;
  end

endmodule

/* tb_idli_ex_checker.sv */
`timescale 1ns/10ps

// Protocol assertions, bound into the execution unit top level.
module tb_idli_ex_checker import idli_ex_pkg::*; (
  input logic            i_ex_gck,
  input logic            i_ex_rst_n,
  input ctr_t            i_ex_ctr,
  input logic            i_ex_enc_vld,
  input logic            i_ex_enc_acp,
  input logic            i_ex_pin_vld,
  input logic            i_ex_wb_vld,
  input logic [PINS-1:0] i_ex_io_pins
);

  int         err_cnt = 0;
  logic [2:0] cyc_q;
  logic       seen_pin_q;

  // A saturating count of cycles since reset keeps $past from looking back
  // across reset. The end of the first pin instruction is remembered too.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      cyc_q      <= '0;
      seen_pin_q <= 1'b0;
    end else begin
      if (cyc_q != 3'd7) begin
        cyc_q <= cyc_q + 3'd1;
      end
      if (&i_ex_ctr && i_ex_pin_vld) begin
        seen_pin_q <= 1'b1;
      end
    end
  end

  // Exactly one of any four consecutive cycles carries the accept strobe.
  acp_one_in_four_a : assert property (@(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    (cyc_q >= 3'd3) |-> $onehot({i_ex_enc_acp, $past(i_ex_enc_acp, 1),
                                 $past(i_ex_enc_acp, 2), $past(i_ex_enc_acp, 3)}))
    else begin
      $error("accept strobe is not high exactly once every four cycles");
      err_cnt++;
    end

  // Trace pulses come five cycles after the accept of a valid word.
  wb_delay_a : assert property (@(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    i_ex_wb_vld |-> (cyc_q >= 3'd5) && $past(i_ex_enc_acp && i_ex_enc_vld, 5))
    else begin
      $error("trace pulse without an accepted word five cycles earlier");
      err_cnt++;
    end

  pins_idle_a : assert property (@(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    !seen_pin_q |-> (i_ex_io_pins == '0))
    else begin
      $error("output pins moved before any pin instruction");
      err_cnt++;
    end

endmodule

/* tb_idli_ex.sv */
`timescale 1ns/10ps

// Testbench for the nibble-serial execution unit. Every instruction is run
// through a reference model when it is issued, and the expected trace,
// predicate and pin values are checked one cycle after its slot ends.
module tb_idli_ex import idli_ex_pkg::*; ();

  localparam real  CLK_NS   = 4.0;
  localparam reg_t ONE_REG  = 4'd15;
  localparam int   LOAD_N   = 1 + 2 * DATA_W;
  localparam int   N_SETUP  = 1 + 8 + 6 * LOAD_N;
  localparam int   N_ALU    = 32;
  localparam int   N_CMP    = 3 * LOAD_N + 1 + 42;
  localparam int   N_COND   = 45;
  localparam int   N_PIN    = 20;
  localparam int   N_RST    = 9;
  localparam int   N_TOTAL  = N_SETUP + N_ALU + N_CMP + N_COND + N_PIN + N_RST;
  localparam int   WD_CYCLES = (N_TOTAL + 10) * SLICES;

  typedef struct packed {
    int              due;
    logic            has_wb;
    reg_t            wb_reg;
    data_t           wb_data;
    logic            pred;
    logic [PINS-1:0] pins;
  } slot_exp_t;

  logic            gck;
  logic            gen_rst_n;
  logic            tb_rst_n;
  logic            rst_n;
  data_t           enc;
  logic            enc_vld;
  logic            enc_acp;
  logic [PINS-1:0] in_pins;
  logic [PINS-1:0] out_pins;
  logic            pred;
  logic            wb_vld;
  reg_t            wb_reg;
  data_t           wb_data;

  integer          seed = 78658;
  int              cyc = 0;
  string           test_name = "setup";
  slot_exp_t       exp_q [$];

  // Reference state.
  data_t           m_regs [REGS];
  logic            m_pred;
  logic [7:0]      m_mask;
  logic [PINS-1:0] m_pins;
  logic [PINS-1:0] m_in_pins;

  assign rst_n = gen_rst_n && tb_rst_n;

  tb_clock_gen clk_gen_i (
    .o_gck   (gck),
    .o_rst_n (gen_rst_n)
  );

  idli_ex_top dut_i (
    .i_ex_gck     (gck),
    .i_ex_rst_n   (rst_n),
    .i_ex_enc     (enc),
    .i_ex_enc_vld (enc_vld),
    .o_ex_enc_acp (enc_acp),
    .i_ex_io_pins (in_pins),
    .o_ex_io_pins (out_pins),
    .o_ex_pred    (pred),
    .o_ex_wb_vld  (wb_vld),
    .o_ex_wb_reg  (wb_reg),
    .o_ex_wb_data (wb_data)
  );

  bind idli_ex_top tb_idli_ex_checker checker_i (
    .i_ex_gck     (i_ex_gck),
    .i_ex_rst_n   (i_ex_rst_n),
    .i_ex_ctr     (ctr),
    .i_ex_enc_vld (i_ex_enc_vld),
    .i_ex_enc_acp (o_ex_enc_acp),
    .i_ex_pin_vld (pin_vld),
    .i_ex_wb_vld  (o_ex_wb_vld),
    .i_ex_io_pins (o_ex_io_pins)
  );

  task automatic fail_with(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act)
      else fail_with($sformatf("mismatch %s %s: expected %0h, actual %0h",
                               test_name, what, exp, act));
  endtask

  function automatic int rnd(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic data_t make_alu(input logic [3:0] op, input reg_t d, input reg_t l,
                                     input reg_t r);
    return {op, d, l, r};
  endfunction

  function automatic data_t make_imm(input logic [3:0] op, input reg_t rg,
                                     input logic [7:0] imm);
    return {op, rg, imm};
  endfunction

  // Random register operation that never overwrites the constant register.
  function automatic data_t rand_alu();
    return make_alu(4'(rnd(5)), reg_t'(rnd(15)), reg_t'(rnd(16)), reg_t'(rnd(16)));
  endfunction

  // Executes one instruction on the model. Returns whether a trace pulse
  // is expected and, if so, its register and word.
  function automatic logic model_step(input data_t w, output reg_t wr, output data_t wd);
    logic [3:0] op;
    reg_t       dst;
    data_t      a;
    data_t      b;
    data_t      res;
    logic [7:0] imm;
    logic       skip;
    logic       has;
    op   = w[15:12];
    dst  = w[11:8];
    imm  = w[7:0];
    a    = m_regs[w[7:4]];
    b    = m_regs[w[3:0]];
    skip = (m_mask[7:1] != 0) && (m_mask[0] != m_pred);
    has  = 1'b0;
    wr   = dst;
    wd   = '0;
    case (op)
      4'd0: res = a + b;
      4'd1: res = a - b;
      4'd2: res = a & b;
      4'd3: res = a | b;
      default: res = a ^ b;
    endcase
    if (!skip) begin
      case (op)
        4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
          has = 1'b1;
          wd  = res;
        end
        4'd5: begin
          case (dst)
            4'd0: m_pred = (a == b);
            4'd1: m_pred = (a != b);
            4'd2: m_pred = ($signed(a) < $signed(b));
            4'd3: m_pred = (a < b);
            4'd4: m_pred = ($signed(a) >= $signed(b));
            4'd5: m_pred = (a >= b);
            default: m_pred = m_pred;
          endcase
        end
        4'd7: begin
          case (imm[3:2])
            2'd0: begin
              has = 1'b1;
              wd  = data_t'(m_in_pins[imm[1:0]]);
            end
            2'd1: m_pins[imm[1:0]] = m_regs[dst][0];
            2'd2: m_pins[imm[1:0]] = ~m_regs[dst][0];
            default: m_pins[imm[1:0]] = m_pred;
          endcase
        end
        default: begin
        end
      endcase
    end
    if (has && wr != REG_ZR) m_regs[wr] = wd;
    if (op == 4'd6 && !skip) m_mask = imm;
    else m_mask = m_mask >> 1;
    return has;
  endfunction

  task automatic set_pins(input logic [PINS-1:0] v);
    in_pins   = v;
    m_in_pins = v;
  endtask

  // Offers a word until it is accepted and queues what its slot must show.
  task automatic issue(input data_t w);
    slot_exp_t e;
    reg_t      r;
    data_t     d;
    e.has_wb  = model_step(w, r, d);
    e.wb_reg  = r;
    e.wb_data = d;
    e.pred    = m_pred;
    e.pins    = m_pins;
    enc       = w;
    enc_vld   = 1'b1;
    while (!enc_acp) begin
      @(posedge gck);
      #0.5;
    end
    @(posedge gck);
    #0.5;
    enc_vld = 1'b0;
    e.due   = cyc + SLICES;
    exp_q.push_back(e);
  endtask

  // Builds a value by doubling and adding the constant one.
  task automatic load_reg(input reg_t r, input data_t v);
    issue(make_alu(OP_OR, r, REG_ZR, REG_ZR));
    for (int i = DATA_W - 1; i >= 0; i--) begin
      issue(make_alu(OP_ADD, r, r, r));
      if (v[i]) issue(make_alu(OP_ADD, r, r, ONE_REG));
    end
  endtask

  task automatic apply_reset();
    tb_rst_n = 1'b0;
    exp_q.delete();
    m_pred = 1'b0;
    m_mask = '0;
    m_pins = '0;
    @(negedge gck);
    check_eq("pins in reset", 0, out_pins);
    check_eq("pred in reset", 0, pred);
    check_eq("wb_vld in reset", 0, wb_vld);
    repeat (2) @(posedge gck);
    #0.5;
    tb_rst_n = 1'b1;
  endtask

  always @(posedge gck) cyc <= cyc + 1;

  // Compares the trace, predicate and pins against the queued slots.
  always @(negedge gck) begin
    slot_exp_t e;
    if (rst_n) begin
      if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
        e = exp_q.pop_front();
        check_eq("wb_vld", e.has_wb, wb_vld);
        check_eq("pred", e.pred, pred);
        check_eq("pins", e.pins, out_pins);
        if (e.has_wb) begin
          check_eq("wb_reg", e.wb_reg, wb_reg);
          check_eq("wb_data", e.wb_data, wb_data);
        end
      end else begin
        check_eq("idle wb_vld", 0, wb_vld);
      end
    end
  end

  initial begin
    #(WD_CYCLES * CLK_NS);
    fail_with("Timeout: the tests did not finish in the expected time");
  end

  initial begin
    enc      = '0;
    enc_vld  = 1'b0;
    tb_rst_n = 1'b1;
    m_pred   = 1'b0;
    m_mask   = '0;
    m_pins   = '0;
    for (int i = 0; i < REGS; i++) m_regs[i] = '0;
    set_pins('0);
    @(posedge gen_rst_n);
    @(posedge gck);
    #0.5;

    // The constant one lives in r15 and every other register starts defined.
    set_pins(4'b0001);
    issue(make_imm(OP_PIN, ONE_REG, {4'd0, PIN_IN, 2'd0}));
    for (int r = 7; r < 15; r++) issue(make_alu(OP_OR, reg_t'(r), REG_ZR, REG_ZR));
    for (int r = 1; r < 7; r++) load_reg(reg_t'(r), data_t'($random(seed)));

    test_name = "alu";
    for (int i = 0; i < 30; i++) issue(rand_alu());
    issue(make_alu(OP_ADD, REG_ZR, 4'd1, 4'd2));
    issue(make_alu(OP_OR, 4'd3, REG_ZR, REG_ZR));

    test_name = "cmp";
    load_reg(4'd7, 16'h8000);
    load_reg(4'd8, 16'h7FFF);
    load_reg(4'd9, 16'hFFFF);
    issue(make_alu(OP_OR, 4'd10, 4'd1, REG_ZR));
    for (int k = 0; k < 6; k++) begin
      issue(make_alu(OP_CMP, reg_t'(k), 4'd1, 4'd10));
      issue(make_alu(OP_CMP, reg_t'(k), 4'd7, 4'd8));
      issue(make_alu(OP_CMP, reg_t'(k), 4'd8, 4'd7));
      issue(make_alu(OP_CMP, reg_t'(k), REG_ZR, 4'd9));
      issue(make_alu(OP_CMP, reg_t'(k), 4'd9, REG_ZR));
      issue(make_alu(OP_CMP, reg_t'(k), 4'd1, 4'd2));
      issue(make_alu(OP_CMP, reg_t'(k), 4'd3, 4'd4));
    end

    // With the predicate set, the first instruction is skipped and the
    // mask runs out after two more.
    test_name = "cond";
    issue(make_alu(OP_CMP, CMP_EQ, REG_ZR, REG_ZR));
    issue(make_imm(OP_COND, REG_ZR, 8'b0000_0110));
    for (int i = 0; i < 3; i++) issue(rand_alu());
    for (int k = 0; k < 4; k++) begin
      issue(make_alu(OP_CMP, reg_t'(rnd(6)), reg_t'(rnd(16)), reg_t'(rnd(16))));
      issue(make_imm(OP_COND, REG_ZR, 8'($random(seed))));
      for (int i = 0; i < 8; i++) issue(rand_alu());
    end

    test_name = "pin_in";
    for (int i = 0; i < 8; i++) begin
      set_pins(4'($random(seed)));
      issue(make_imm(OP_PIN, reg_t'(rnd(14) + 1), {4'd0, PIN_IN, 2'(rnd(4))}));
    end

    test_name = "pin_out";
    for (int p = 0; p < PINS; p++) begin
      issue(make_imm(OP_PIN, reg_t'(rnd(15)), {4'd0, PIN_OUT, 2'(p)}));
      issue(make_imm(OP_PIN, reg_t'(rnd(15)), {4'd0, PIN_OUTN, 2'(p)}));
      issue(make_imm(OP_PIN, REG_ZR, {4'd0, PIN_PRED, 2'(p)}));
    end

    // Reset lands while the trace of the write to r12 is showing, with the
    // predicate, an output pin and a live mask all set.
    test_name = "reset";
    issue(make_imm(OP_PIN, REG_ZR, {4'd0, PIN_OUTN, 2'd2}));
    issue(make_alu(OP_CMP, CMP_EQ, REG_ZR, REG_ZR));
    issue(make_imm(OP_COND, REG_ZR, 8'hFE));
    issue(make_alu(OP_ADD, REG_ZR, 4'd1, 4'd2));
    issue(make_alu(OP_ADD, 4'd12, 4'd1, 4'd2));
    issue(make_alu(OP_CMP, CMP_EQ, REG_ZR, REG_ZR));
    apply_reset();
    issue(make_alu(OP_ADD, 4'd11, 4'd1, 4'd2));
    issue(make_imm(OP_PIN, REG_ZR, {4'd0, PIN_PRED, 2'd0}));
    issue(make_alu(OP_CMP, CMP_EQ, REG_ZR, REG_ZR));

    while (exp_q.size() != 0) @(negedge gck);
    @(posedge gck);
    if (dut_i.checker_i.err_cnt == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("A bound protocol assertion failed during the run");
      $display("Testbench failed");
      $fatal(1, "protocol assertion failure");
    end
  end

endmodule

/* project.f */
idli_ex_pkg.sv
idli_ex_fetch.sv
idli_ex_decode.sv
idli_ex_rf.sv
idli_ex_alu.sv
idli_ex_pred.sv
idli_ex_io.sv
idli_ex_top.sv
tb_clock_gen.sv
tb_idli_ex_checker.sv
tb_idli_ex.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_idli_ex
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
